/* list.f */
+incdir+verilog
verilog/tag_pkg.sv
verilog/tag_array.sv
verilog/tag_way.sv
verilog/nru_policy.sv
verilog/icache_tag.sv
tests/icache_tag_tb.sv

/* tests/icache_tag_tb.sv */
// icache tag testbench: reset sweep timing, pattern replay and random miss probes.
`timescale 1ns/1ps
`include "tag_settings.svh"

module icache_tag_tb;

  import tag_pkg::*;

  localparam int MAX_REQS     = 64;
  localparam int COLS         = 6;
  localparam int END_OP       = 3;
  localparam int PROBES       = 16;
  localparam int SWEEP_CYCLES = 1 << `TAG_INDEX_BITS;

  typedef struct packed {
    logic                         hit;
    logic [$clog2(`TAG_WAYS)-1:0] way;
    logic                         evict_valid;
    logic [`TAG_BITS-1:0]         evict_tag;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        req_valid;
  tag_req_t    req;
  logic        ready;
  logic        rsp_valid;
  tag_rsp_t    rsp;

  logic [31:0] pat_mem [MAX_REQS*COLS];
  tag_req_t    req_q [$];
  expect_t     exp_q [$];
  int          seed;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          limit_cycles;

  icache_tag uut (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req       (req),
    .ready     (ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // checks
  // --------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Fail %s: expected 0x%0h, got 0x%0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Error: %s at %0t", what, $time);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // --------------------
  // stimulus
  // --------------------
  task automatic load_patterns(output int count);
    int       base;
    logic     done;
    tag_req_t r;
    expect_t  e;
    $readmemh("tests/tag_patterns.txt", pat_mem);
    count = 0;
    done  = 1'b0;
    while (!done && count < MAX_REQS) begin
      base = count * COLS;
      if ($isunknown(pat_mem[base]) || pat_mem[base] == END_OP) begin
        done = 1'b1;
      end else begin
        r.op          = tag_op_e'(pat_mem[base][1:0]);
        r.addr        = pat_mem[base+1][`TAG_BITS+`TAG_INDEX_BITS-1:0];
        e.hit         = pat_mem[base+2][0];
        e.way         = pat_mem[base+3][$clog2(`TAG_WAYS)-1:0];
        e.evict_valid = pat_mem[base+4][0];
        e.evict_tag   = pat_mem[base+5][`TAG_BITS-1:0];
        req_q.push_back(r);
        exp_q.push_back(e);
        count++;
      end
    end
    check_cond(count > 0, "pattern file is empty or missing");
  endtask

  // probe tags start with 0xE, which no pattern ever fills.
  task automatic add_probes();
    logic [31:0] rnd;
    tag_req_t    r;
    for (int p = 0; p < PROBES; p++) begin
      rnd    = $random(seed);
      r.op   = OP_LOOKUP;
      r.addr = {4'hE, rnd[`TAG_BITS-5:0], rnd[`TAG_BITS +: `TAG_INDEX_BITS]};
      req_q.push_back(r);
      exp_q.push_back('0);
    end
  endtask

  // drives on falling edges and checks each response one cycle after acceptance.
  task automatic run_requests(input int first, input int last);
    int       next;
    int       pend;
    logic     was_write;
    tag_rsp_t got;
    next      = first;
    pend      = -1;
    was_write = 1'b0;
    while (next < last || pend >= 0 || was_write) begin
      @(negedge clk);
      if (was_write) check_cond(ready, "ready still low two cycles after a write");
      was_write = 1'b0;
      if (pend >= 0) begin
        got = rsp;
        check_cond(rsp_valid, "no response in the cycle after acceptance");
        check_value("rsp.op", req_q[pend].op, got.op);
        check_value("rsp.hit", exp_q[pend].hit, got.hit);
        check_value("rsp.way", exp_q[pend].way, got.way);
        check_value("rsp.parity_err", 0, got.parity_err);
        check_value("rsp.evict_valid", exp_q[pend].evict_valid, got.evict_valid);
        check_value("rsp.evict_tag", exp_q[pend].evict_tag, got.evict_tag);
        if (req_q[pend].op != OP_LOOKUP) begin
          check_cond(!ready, "ready high in the write cycle of a fill or invalidate");
          was_write = 1'b1;
        end
        pend = -1;
      end else begin
        check_cond(!rsp_valid, "response seen without an accepted request");
      end
      if (next < last && ready) begin
        req_valid = 1'b1;
        req       = req_q[next];
        pend      = next;
        next++;
      end else begin
        req_valid = 1'b0;
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int npat;
    int run_errors;
    int low_cycles;
    seed         = 78695;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    load_patterns(npat);
    add_probes();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst          = 1'b0;
    limit_cycles = SWEEP_CYCLES + 3 * req_q.size();

    // ready stays low while every set is cleared.
    run_errors = errors;
    low_cycles = 0;
    while (!ready) begin
      low_cycles++;
      @(negedge clk);
    end
    check_value("ready low cycles", SWEEP_CYCLES, low_cycles);
    report_test("reset sweep", run_errors);

    run_errors = errors;
    run_requests(0, npat);
    report_test("pattern replay", run_errors);

    run_errors = errors;
    run_requests(npat, req_q.size());
    report_test("miss probes", run_errors);

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // budget is the sweep plus three cycles per request.
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", limit_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* tests/tag_patterns.txt */
// columns: op addr hit way evict_valid evict_tag (hex), addr is tag above a 6-bit index
// op 0 lookup, 1 fill, 2 invalidate, 3 ends the list
0 0000045 0 0 0 00000
0 00000AA 0 0 0 00000
1 0000045 0 0 0 00000
1 0000085 0 1 0 00000
1 00000C5 0 2 0 00000
1 0000105 0 3 0 00000
0 0000045 1 0 0 00000
0 0000085 1 1 0 00000
0 00000C5 1 2 0 00000
0 0000105 1 3 0 00000
1 0000145 0 0 1 00001
0 0000045 0 0 0 00000
0 0000145 1 0 0 00000
0 0000085 1 1 0 00000
1 0000185 0 0 1 00005
0 0000145 0 0 0 00000
0 0000185 1 0 0 00000
1 00001C5 0 2 1 00003
1 0000105 1 3 0 00000
2 0000085 1 1 0 00000
0 0000085 0 0 0 00000
2 0000085 0 0 0 00000
0 0000185 1 0 0 00000
1 0000205 0 1 0 00000
0 0000205 1 1 0 00000
0 00001C5 1 2 0 00000
1 0000245 0 0 1 00006
0 0000185 0 0 0 00000
0 0000105 1 3 0 00000
1 0000285 0 1 1 00008
0 0000245 1 0 0 00000
0 0000285 1 1 0 00000
0 0000205 0 0 0 00000
1 000006A 0 0 0 00000
0 000006A 1 0 0 00000
0 0000045 0 0 0 00000
1 2AF37BF 0 0 0 00000
0 2AF37BF 1 0 0 00000
2 2AF37BF 1 0 0 00000
0 2AF37BF 0 0 0 00000
1 2AF37BF 0 0 0 00000
3 0000000 0 0 0 00000

/* verilog/icache_tag.sv */
// icache tag top: request stage, reset sweep, way merge and response build.
`timescale 1ns/1ps
`include "tag_settings.svh"

module icache_tag (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  tag_pkg::tag_req_t req,
  output logic              ready,
  output logic              rsp_valid,
  output tag_pkg::tag_rsp_t rsp
);

  import tag_pkg::*;

  localparam int WAY_BITS = $clog2(`TAG_WAYS);

  tag_req_t                   s1_req;
  tag_req_t                   way_req;
  logic                       s1_valid;
  logic                       accept;
  logic                       sweep;
  logic [`TAG_INDEX_BITS-1:0] sweep_cnt;
  logic                       wr_clear;
  logic                       any_hit;
  logic [WAY_BITS-1:0]        hit_way;
  logic [WAY_BITS-1:0]        victim;
  logic [`TAG_WAYS-1:0]       way_hit;
  logic [`TAG_WAYS-1:0]       way_perr;
  logic [`TAG_WAYS-1:0]       way_valid;
  logic [`TAG_WAYS-1:0]       way_wr_en;
  tag_entry_u                 way_entry [`TAG_WAYS];
  tag_entry_u                 victim_entry;

  // --------------------
  // request stage
  // --------------------

  // fills and invalidates write in their response cycle, so hold one cycle.
  assign ready  = !sweep && !(s1_valid && s1_req.op != OP_LOOKUP);
  assign accept = req_valid && ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      sweep     <= 1'b1;
      sweep_cnt <= '0;
    end else begin
      s1_valid <= accept;
      if (sweep) begin
        sweep_cnt <= sweep_cnt + 1'b1;
        if (sweep_cnt == '1) sweep <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) s1_req <= req;
  end

  // sweep steers every way to the set being cleared.
  always_comb begin
    way_req = s1_req;
    if (sweep) begin
      way_req.addr = {{`TAG_BITS{1'b0}}, sweep_cnt};
    end
  end

  assign wr_clear = sweep || (s1_valid && s1_req.op == OP_INVAL);

  // --------------------
  // ways and replacement
  // --------------------
  for (genvar w = 0; w < `TAG_WAYS; w++) begin : g_way
    tag_way u_way (
      .clk        (clk),
      .rst        (rst),
      .rd_en      (accept),
      .rd_index   (req.addr[`TAG_INDEX_BITS-1:0]),
      .cur        (way_req),
      .wr_en      (way_wr_en[w]),
      .wr_clear   (wr_clear),
      .hit        (way_hit[w]),
      .parity_err (way_perr[w]),
      .entry      (way_entry[w])
    );

    assign way_valid[w] = way_entry[w].f.valid;

    // victim on a missing fill, hit way on an invalidate.
    assign way_wr_en[w] = sweep || (s1_valid &&
        ((s1_req.op == OP_FILL && !any_hit && victim == WAY_BITS'(w)) ||
         (s1_req.op == OP_INVAL && way_hit[w])));
  end

  nru_policy u_nru (
    .clk         (clk),
    .rst         (rst),
    .rd_en       (accept),
    .rd_index    (req.addr[`TAG_INDEX_BITS-1:0]),
    .cur         (s1_req),
    .cur_valid   (s1_valid),
    .way_hit     (way_hit),
    .way_valid   (way_valid),
    .sweep       (sweep),
    .sweep_index (sweep_cnt),
    .victim      (victim)
  );

  // --------------------
  // response
  // --------------------
  assign any_hit      = |way_hit;
  assign victim_entry = way_entry[victim];
  assign rsp_valid    = s1_valid;

  always_comb begin
    hit_way = '0;
    for (int w = `TAG_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = WAY_BITS'(w);
    end
  end

  // a fill that hits reports like a lookup.
  always_comb begin
    rsp            = '0;
    rsp.op         = s1_req.op;
    rsp.hit        = any_hit;
    rsp.parity_err = |way_perr;
    if (any_hit) begin
      rsp.way = hit_way;
    end else if (s1_req.op == OP_FILL) begin
      rsp.way         = victim;
      rsp.evict_valid = victim_entry.f.valid;
      rsp.evict_tag   = victim_entry.f.valid ? victim_entry.f.tag : '0;
    end
  end

endmodule

/* verilog/nru_policy.sv */
// not-recently-used replacement: per-set use bits, victim choice and update.
`timescale 1ns/1ps
`include "tag_settings.svh"

module nru_policy (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         rd_en,
  input  logic [`TAG_INDEX_BITS-1:0]   rd_index,
  input  tag_pkg::tag_req_t            cur,
  input  logic                         cur_valid,
  input  logic [`TAG_WAYS-1:0]         way_hit,
  input  logic [`TAG_WAYS-1:0]         way_valid,
  input  logic                         sweep,
  input  logic [`TAG_INDEX_BITS-1:0]   sweep_index,
  output logic [$clog2(`TAG_WAYS)-1:0] victim
);

  import tag_pkg::*;

  localparam int WAY_BITS = $clog2(`TAG_WAYS);

  logic [`TAG_INDEX_BITS-1:0] cur_index;
  logic [`TAG_WAYS-1:0]       arr_bits;
  logic [`TAG_WAYS-1:0]       nru_bits;
  logic [`TAG_WAYS-1:0]       upd_mask;
  logic [`TAG_WAYS-1:0]       nru_set;
  logic [`TAG_WAYS-1:0]       wr_bits;
  logic [`TAG_INDEX_BITS-1:0] wr_index;
  logic [WAY_BITS-1:0]        hit_way;
  logic [WAY_BITS-1:0]        upd_way;
  logic                       any_hit;
  logic                       upd_en;
  logic                       wr_en;
  logic                       byp_valid;
  logic [`TAG_INDEX_BITS-1:0] byp_index;
  logic [`TAG_WAYS-1:0]       byp_bits;

  assign cur_index = cur.addr[`TAG_INDEX_BITS-1:0];

  tag_array #(
    .WIDTH (`TAG_WAYS)
  ) u_bits (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (arr_bits),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (wr_bits)
  );

  // last written set wins over the array copy.
  assign nru_bits = (byp_valid && byp_index == cur_index) ? byp_bits : arr_bits;

  // --------------------
  // victim choice
  // --------------------
  always_comb begin
    victim  = '0;
    hit_way = '0;
    for (int w = `TAG_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = WAY_BITS'(w);
    end
    if (!(&way_valid)) begin
      for (int w = `TAG_WAYS - 1; w >= 0; w--) begin
        if (!way_valid[w]) victim = WAY_BITS'(w);
      end
    end else begin
      for (int w = `TAG_WAYS - 1; w >= 0; w--) begin
        if (!nru_bits[w]) victim = WAY_BITS'(w);
      end
    end
  end

  // --------------------
  // update
  // --------------------
  assign any_hit  = |way_hit;
  assign upd_way  = any_hit ? hit_way : victim;
  assign upd_mask = `TAG_WAYS'(1) << upd_way;
  assign nru_set  = nru_bits | upd_mask;

  // lookup hits and fills touch the bits, misses and invalidates do not.
  assign upd_en   = cur_valid && ((cur.op == OP_LOOKUP && any_hit) || cur.op == OP_FILL);
  assign wr_en    = sweep || upd_en;
  assign wr_index = sweep ? sweep_index : cur_index;
  assign wr_bits  = sweep ? '0 : ((&nru_set) ? upd_mask : nru_set);

  always_ff @(posedge clk) begin
    if (rst) begin
      byp_valid <= 1'b0;
    end else if (wr_en) begin
      byp_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      byp_index <= wr_index;
      byp_bits  <= wr_bits;
    end
  end

  // ways never hold the same tag twice in one set.
  a_one_hit: assert property (
    @(posedge clk) disable iff (rst) cur_valid |-> $onehot0(way_hit)
  ) else $error("nru_policy: more than one way hit");

endmodule

/* verilog/tag_array.sv */
// single-port-write, single-port-read per-set array read through a registered index.
`timescale 1ns/1ps
`include "tag_settings.svh"

module tag_array #(
  parameter int WIDTH = `TAG_BITS + 2
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_en,
  input  logic [`TAG_INDEX_BITS-1:0] rd_index,
  output logic [WIDTH-1:0]           rd_data,
  input  logic                       wr_en,
  input  logic [`TAG_INDEX_BITS-1:0] wr_index,
  input  logic [WIDTH-1:0]           wr_data
);

  localparam int DEPTH = 1 << `TAG_INDEX_BITS;

  logic [WIDTH-1:0]           mem [DEPTH];
  logic [`TAG_INDEX_BITS-1:0] rd_index_q;

  // read index is held until the next enabled read.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_index_q <= '0;
    end else if (rd_en) begin
      rd_index_q <= rd_index;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // data follows the latched index, so a write lands before the next read.
  assign rd_data = mem[rd_index_q];

  a_wr_index_known: assert property (
    @(posedge clk) disable iff (rst) wr_en |-> !$isunknown(wr_index)
  ) else $error("tag_array: write with unknown index");

endmodule

/* verilog/tag_pkg.sv */
// icache tag types shared by the ways, the replacement logic and the top level.
`include "tag_settings.svh"

package tag_pkg;

  // --------------------
  // operations
  // --------------------
  typedef enum logic [1:0] {
    OP_LOOKUP = 2'd0,
    OP_FILL   = 2'd1,
    OP_INVAL  = 2'd2
  } tag_op_e;

  // --------------------
  // stored entry
  // --------------------

  // parity sits in the low bit so the whole word xors to zero.
  typedef struct packed {
    logic                 valid;
    logic [`TAG_BITS-1:0] tag;
    logic                 parity;
  } tag_fields_t;

  typedef union packed {
    tag_fields_t          f;
    logic [`TAG_BITS+1:0] raw;
  } tag_entry_u;

  // --------------------
  // request and response
  // --------------------
  typedef struct packed {
    tag_op_e                                op;
    logic [`TAG_BITS+`TAG_INDEX_BITS-1:0]   addr;
  } tag_req_t;

  typedef struct packed {
    tag_op_e                        op;
    logic                           hit;
    logic [$clog2(`TAG_WAYS)-1:0]   way;
    logic                           parity_err;
    logic                           evict_valid;
    logic [`TAG_BITS-1:0]           evict_tag;
  } tag_rsp_t;

endpackage

/* verilog/tag_settings.svh */
// icache tag geometry: way count, set index width and stored tag width.
`ifndef TAG_SETTINGS_SVH
`define TAG_SETTINGS_SVH

// --------------------
// cache geometry
// --------------------

// number of ways per set.
`define TAG_WAYS 4

// set index width, 64 sets.
`define TAG_INDEX_BITS 6

// stored tag width.
// line address is tag above index, 26 bits in total.
`define TAG_BITS 20

`endif

/* verilog/tag_way.sv */
// one cache way: tag storage, parity check, tag compare and write word build.
`timescale 1ns/1ps
`include "tag_settings.svh"

module tag_way (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_en,
  input  logic [`TAG_INDEX_BITS-1:0] rd_index,
  input  tag_pkg::tag_req_t          cur,
  input  logic                       wr_en,
  input  logic                       wr_clear,
  output logic                       hit,
  output logic                       parity_err,
  output tag_pkg::tag_entry_u        entry
);

  import tag_pkg::*;

  localparam int ENTRY_BITS = `TAG_BITS + 2;

  logic [`TAG_BITS-1:0]        cur_tag;
  logic [`TAG_INDEX_BITS-1:0]  cur_index;
  logic [ENTRY_BITS-1:0]       rd_word;
  tag_entry_u                  wr_word;

  assign cur_tag   = cur.addr[`TAG_INDEX_BITS +: `TAG_BITS];
  assign cur_index = cur.addr[`TAG_INDEX_BITS-1:0];

  // --------------------
  // storage
  // --------------------
  tag_array #(
    .WIDTH (ENTRY_BITS)
  ) u_array (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_data  (rd_word),
    .wr_en    (wr_en),
    .wr_index (cur_index),
    .wr_data  (wr_word.raw)
  );

  // --------------------
  // read side
  // --------------------
  assign entry = tag_entry_u'(rd_word);

  // valid entry with matching tag.
  assign hit = entry.f.valid && (entry.f.tag == cur_tag);

  // stored words have even parity over all bits.
  assign parity_err = entry.f.valid && (^entry.raw);

  // --------------------
  // write side
  // --------------------

  // new entry for a fill, zeros for invalidate and sweep.
  always_comb begin
    wr_word = '0;
    if (!wr_clear) begin
      wr_word.f.valid  = 1'b1;
      wr_word.f.tag    = cur_tag;
      wr_word.f.parity = 1'b0;
      wr_word.f.parity = ^wr_word.raw;
    end
  end

  // only even-parity words are ever written, so a matching entry stays clean.
  a_hit_no_parity: assert property (
    @(posedge clk) disable iff (rst || wr_clear) !(hit && parity_err)
  ) else $error("tag_way: hit entry carries a parity error");

endmodule
